// ==== design/link_pkg.sv ====
`default_nettype none

package link_pkg;

  // Physical lane format
  localparam int NumLanes = 8;

  // A beat carries one lane word on each edge of the forwarded clock
  localparam int FlitWidth    = 64;
  localparam int BeatWidth    = 2 * NumLanes;
  localparam int BeatsPerFlit = FlitWidth / BeatWidth;

  typedef logic [FlitWidth-1:0]            flit_t;
  typedef logic [BeatWidth-1:0]            beat_t;
  typedef logic [NumLanes-1:0]             lanes_t;
  typedef logic [$clog2(BeatsPerFlit)-1:0] beat_cnt_t;

  // Index of the final beat of a flit
  localparam beat_cnt_t LastBeat = beat_cnt_t'(BeatsPerFlit - 1);

  // Buffer depths in flits on transmit and in beats on receive
  localparam int TxFifoDepth = 2;
  localparam int RxFifoDepth = 8;

endpackage : link_pkg

`default_nettype wire

// ==== design/cfg_pkg.sv ====
`default_nettype none

package cfg_pkg;

  // Wishbone bus widths
  localparam int WbAddrWidth = 8;
  localparam int WbDataWidth = 32;

  typedef logic [WbAddrWidth-1:0] wb_addr_t;
  typedef logic [WbDataWidth-1:0] wb_data_t;

  // Register byte addresses
  localparam wb_addr_t AddrCtrl    = 8'h00;
  localparam wb_addr_t AddrClkDiv  = 8'h04;
  localparam wb_addr_t AddrStatus  = 8'h08;
  localparam wb_addr_t AddrTxCount = 8'h0C;
  localparam wb_addr_t AddrRxCount = 8'h10;

  // Field positions
  localparam int CtrlLinkEnBit     = 0;
  localparam int CtrlClearBit      = 1;
  localparam int StatusOverflowBit = 0;

  // System cycles per forwarded-clock half period
  typedef logic [7:0] clk_div_t;
  localparam clk_div_t MinClkDiv   = 8'd2;
  localparam clk_div_t ClkDivReset = 8'd4;

  typedef logic [31:0] count_t;

endpackage : cfg_pkg

`default_nettype wire

// ==== design/link_cfg_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Control fields out of the register block, events back into it
interface link_cfg_if;

  cfg_pkg::clk_div_t clk_div;
  logic              link_en;
  logic              clear;
  logic              rx_overflow;
  logic              tx_flit_done;
  logic              rx_flit_done;

  modport regs (
    output clk_div, link_en, clear,
    input  rx_overflow, tx_flit_done, rx_flit_done
  );

  modport link (
    input  clk_div, link_en, clear,
    output rx_overflow, tx_flit_done, rx_flit_done
  );

endinterface : link_cfg_if

`default_nettype wire

// ==== design/stream_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

// Circular buffer with valid/ready handshakes on both sides
module stream_fifo #(
  parameter type data_t = logic,
  parameter int  Depth  = 2
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  clear_i,
  input  data_t data_i,
  input  logic  valid_i,
  output logic  ready_o,
  output data_t data_o,
  output logic  valid_o,
  input  logic  ready_i
);

  typedef logic [$clog2(Depth)-1:0]   ptr_t;
  typedef logic [$clog2(Depth+1)-1:0] cnt_t;

  data_t mem_q [Depth];
  ptr_t  wr_ptr_q;
  ptr_t  rd_ptr_q;
  cnt_t  count_q;
  logic  push;
  logic  pop;

  assign ready_o = (count_q != cnt_t'(Depth));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i & ready_o;
  assign pop     = valid_o & ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Occupancy only moves when exactly one side transfers
      if (push != pop) begin
        count_q <= push ? count_q + 1'b1 : count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule : stream_fifo

`default_nettype wire

// ==== design/flit_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

// Splits each flit into beats starting with the least significant one
module flit_serializer (
  input  logic            clk_i,
  input  logic            arst_n_i,
  link_cfg_if.link        cfg,
  input  link_pkg::flit_t flit_i,
  input  logic            flit_valid_i,
  output logic            flit_ready_o,
  output link_pkg::beat_t beat_o,
  output logic            beat_valid_o,
  input  logic            beat_ready_i
);

  link_pkg::flit_t     flit_q;
  link_pkg::beat_cnt_t beat_idx_q;
  logic                full_q;
  logic                beat_hs;
  logic                last_hs;
  logic                flit_hs;

  assign beat_valid_o = full_q;
  assign beat_o       = flit_q[link_pkg::BeatWidth-1:0];
  assign beat_hs      = full_q & beat_ready_i;
  assign last_hs      = beat_hs & (beat_idx_q == link_pkg::LastBeat);

  // A new flit may enter in the cycle the last beat leaves
  assign flit_ready_o = ~full_q | last_hs;
  assign flit_hs      = flit_valid_i & flit_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q     <= 1'b0;
      beat_idx_q <= '0;
    end else if (cfg.clear) begin
      full_q     <= 1'b0;
      beat_idx_q <= '0;
    end else begin
      if (beat_hs) begin
        beat_idx_q <= beat_idx_q + 1'b1;
      end
      if (flit_hs) begin
        full_q <= 1'b1;
      end else if (last_hs) begin
        full_q <= 1'b0;
      end
    end
  end

  // Shift the next beat down into the low bits
  always_ff @(posedge clk_i) begin
    if (flit_hs) begin
      flit_q <= flit_i;
    end else if (beat_hs) begin
      flit_q <= flit_q >> link_pkg::BeatWidth;
    end
  end

endmodule : flit_serializer

`default_nettype wire

// ==== design/ddr_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

// Forwarded clock generation and DDR lane driver
module ddr_tx (
  input  logic             clk_i,
  input  logic             arst_n_i,
  link_cfg_if.link         cfg,
  input  link_pkg::beat_t  beat_i,
  input  logic             beat_valid_i,
  output logic             beat_ready_o,
  output logic             ddr_rcv_clk_o,
  output link_pkg::lanes_t ddr_o
);

  link_pkg::beat_t     beat_q;
  link_pkg::beat_cnt_t beat_idx_q;
  cfg_pkg::clk_div_t   div_cnt_q;
  logic                active_q;
  logic                phase_q;
  logic                half_end;
  logic                period_end;
  logic                clk_toggle;
  logic                take;

  // Phase 0 carries the low lane word, phase 1 the high one
  assign half_end   = active_q & (div_cnt_q >= cfg.clk_div - 1'b1);
  assign period_end = half_end & phase_q;
  // Clock edge sits in the middle of each data window
  assign clk_toggle = active_q & (div_cnt_q == (cfg.clk_div >> 1) - 1'b1);

  assign beat_ready_o = cfg.link_en & (~active_q | period_end);
  assign take         = beat_valid_i & beat_ready_o;

  assign cfg.tx_flit_done = period_end & (beat_idx_q == link_pkg::LastBeat);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q      <= 1'b0;
      phase_q       <= 1'b0;
      div_cnt_q     <= '0;
      beat_idx_q    <= '0;
      ddr_rcv_clk_o <= 1'b0;
      ddr_o         <= '0;
    end else if (cfg.clear) begin
      active_q      <= 1'b0;
      phase_q       <= 1'b0;
      div_cnt_q     <= '0;
      beat_idx_q    <= '0;
      ddr_rcv_clk_o <= 1'b0;
    end else begin
      if (clk_toggle) begin
        ddr_rcv_clk_o <= ~phase_q;
      end
      if (period_end) begin
        beat_idx_q <= beat_idx_q + 1'b1;
      end
      if (take) begin
        active_q  <= 1'b1;
        phase_q   <= 1'b0;
        div_cnt_q <= '0;
        ddr_o     <= beat_i[link_pkg::NumLanes-1:0];
      end else if (half_end && !phase_q) begin
        phase_q   <= 1'b1;
        div_cnt_q <= '0;
        ddr_o     <= beat_q[link_pkg::BeatWidth-1:link_pkg::NumLanes];
      end else if (period_end) begin
        active_q <= 1'b0;
      end else if (active_q) begin
        div_cnt_q <= div_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      beat_q <= beat_i;
    end
  end

endmodule : ddr_tx

`default_nettype wire

// ==== design/ddr_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

// Samples the forwarded clock and lanes and assembles beats
module ddr_rx (
  input  logic             clk_i,
  input  logic             arst_n_i,
  link_cfg_if.link         cfg,
  input  logic             ddr_rcv_clk_i,
  input  link_pkg::lanes_t ddr_i,
  output link_pkg::beat_t  beat_o,
  output logic             beat_valid_o,
  input  logic             beat_ready_i
);

  logic [1:0]       clk_sync_q;
  logic             clk_prev_q;
  link_pkg::lanes_t lanes_s1_q;
  link_pkg::lanes_t lanes_s2_q;
  link_pkg::lanes_t low_q;
  logic             low_valid_q;
  logic             rise;
  logic             fall;

  assign rise = clk_sync_q[1] & ~clk_prev_q;
  assign fall = ~clk_sync_q[1] & clk_prev_q;

  // The wire cannot be stalled so a beat meeting a full FIFO is lost
  assign cfg.rx_overflow = beat_valid_o & ~beat_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      clk_sync_q   <= '0;
      clk_prev_q   <= 1'b0;
      low_valid_q  <= 1'b0;
      beat_valid_o <= 1'b0;
    end else begin
      clk_sync_q <= {clk_sync_q[0], ddr_rcv_clk_i};
      clk_prev_q <= clk_sync_q[1];
      if (cfg.clear) begin
        low_valid_q  <= 1'b0;
        beat_valid_o <= 1'b0;
      end else begin
        // Only a falling edge that follows a captured low half completes a beat
        beat_valid_o <= fall & low_valid_q;
        if (rise) begin
          low_valid_q <= 1'b1;
        end else if (fall) begin
          low_valid_q <= 1'b0;
        end
      end
    end
  end

  // Lane synchroniser matches the clock path stage for stage
  always_ff @(posedge clk_i) begin
    lanes_s1_q <= ddr_i;
    lanes_s2_q <= lanes_s1_q;
    if (rise) begin
      low_q <= lanes_s2_q;
    end
    if (fall) begin
      beat_o <= {lanes_s2_q, low_q};
    end
  end

endmodule : ddr_rx

`default_nettype wire

// ==== design/flit_deserializer.sv ====
`timescale 1ns/1ps
`default_nettype none

// Rebuilds flits from beats that arrive least significant first
module flit_deserializer (
  input  logic            clk_i,
  input  logic            arst_n_i,
  link_cfg_if.link        cfg,
  input  link_pkg::beat_t beat_i,
  input  logic            beat_valid_i,
  output logic            beat_ready_o,
  output link_pkg::flit_t flit_o,
  output logic            flit_valid_o,
  input  logic            flit_ready_i
);

  link_pkg::flit_t     asm_q;
  link_pkg::beat_cnt_t beat_idx_q;
  logic                beat_hs;
  logic                flit_done;

  // Beat FIFO is held off while a finished flit waits
  assign beat_ready_o     = ~flit_valid_o;
  assign beat_hs          = beat_valid_i & beat_ready_o;
  assign flit_done        = beat_hs & (beat_idx_q == link_pkg::LastBeat);
  assign cfg.rx_flit_done = flit_valid_o & flit_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      beat_idx_q   <= '0;
      flit_valid_o <= 1'b0;
    end else if (cfg.clear) begin
      beat_idx_q   <= '0;
      flit_valid_o <= 1'b0;
    end else begin
      if (beat_hs) begin
        beat_idx_q <= beat_idx_q + 1'b1;
      end
      if (flit_done) begin
        flit_valid_o <= 1'b1;
      end else if (flit_ready_i) begin
        flit_valid_o <= 1'b0;
      end
    end
  end

  // New beats enter at the top and move down
  always_ff @(posedge clk_i) begin
    if (beat_hs) begin
      asm_q <= {beat_i, asm_q[link_pkg::FlitWidth-1:link_pkg::BeatWidth]};
    end
    if (flit_done) begin
      flit_o <= {beat_i, asm_q[link_pkg::FlitWidth-1:link_pkg::BeatWidth]};
    end
  end

endmodule : flit_deserializer

`default_nettype wire

// ==== design/link_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

// Wishbone classic register block for the link
module link_regs (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  cfg_pkg::wb_addr_t wb_adr_i,
  input  cfg_pkg::wb_data_t wb_dat_i,
  output cfg_pkg::wb_data_t wb_dat_o,
  output logic              wb_ack_o,
  link_cfg_if.regs          cfg
);

  logic              req;
  logic              wr_en;
  logic              link_en_q;
  logic              clear_q;
  logic              overflow_q;
  cfg_pkg::clk_div_t clk_div_q;
  cfg_pkg::clk_div_t wr_div;
  cfg_pkg::count_t   tx_count_q;
  cfg_pkg::count_t   rx_count_q;
  cfg_pkg::wb_data_t rdata;

  // A request is served once, in the cycle it is first seen
  assign req    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_en  = req & wb_we_i;
  assign wr_div = cfg_pkg::clk_div_t'(wb_dat_i);

  assign cfg.link_en = link_en_q;
  assign cfg.clear   = clear_q;
  assign cfg.clk_div = clk_div_q;

  //////////////////////////////////////////////////////////////////////
  // Read decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata = '0;
    case (wb_adr_i)
      cfg_pkg::AddrCtrl:    rdata[cfg_pkg::CtrlLinkEnBit] = link_en_q;
      cfg_pkg::AddrClkDiv:  rdata = cfg_pkg::wb_data_t'(clk_div_q);
      cfg_pkg::AddrStatus:  rdata[cfg_pkg::StatusOverflowBit] = overflow_q;
      cfg_pkg::AddrTxCount: rdata = cfg_pkg::wb_data_t'(tx_count_q);
      cfg_pkg::AddrRxCount: rdata = cfg_pkg::wb_data_t'(rx_count_q);
      default:              rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req) begin
      wb_dat_o <= rdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Register state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_ack_o   <= 1'b0;
      link_en_q  <= 1'b0;
      clear_q    <= 1'b0;
      overflow_q <= 1'b0;
      clk_div_q  <= cfg_pkg::ClkDivReset;
      tx_count_q <= '0;
      rx_count_q <= '0;
    end else begin
      wb_ack_o <= req;
      // Clear is a single-cycle pulse
      clear_q  <= wr_en & (wb_adr_i == cfg_pkg::AddrCtrl) & wb_dat_i[cfg_pkg::CtrlClearBit];
      if (wr_en && wb_adr_i == cfg_pkg::AddrCtrl) begin
        link_en_q <= wb_dat_i[cfg_pkg::CtrlLinkEnBit];
      end
      if (wr_en && wb_adr_i == cfg_pkg::AddrClkDiv) begin
        clk_div_q <= (wr_div < cfg_pkg::MinClkDiv) ? cfg_pkg::MinClkDiv : wr_div;
      end
      // A new overflow wins over a simultaneous write-one-to-clear
      if (cfg.rx_overflow) begin
        overflow_q <= 1'b1;
      end else if (wr_en && wb_adr_i == cfg_pkg::AddrStatus &&
                   wb_dat_i[cfg_pkg::StatusOverflowBit]) begin
        overflow_q <= 1'b0;
      end
      if (clear_q) begin
        tx_count_q <= '0;
        rx_count_q <= '0;
      end else begin
        tx_count_q <= tx_count_q + cfg_pkg::count_t'(cfg.tx_flit_done);
        rx_count_q <= rx_count_q + cfg_pkg::count_t'(cfg.rx_flit_done);
      end
    end
  end

endmodule : link_regs

`default_nettype wire

// ==== design/serial_link_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module serial_link_top (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  link_pkg::flit_t   flit_i,
  input  logic              flit_valid_i,
  output logic              flit_ready_o,
  output link_pkg::flit_t   flit_o,
  output logic              flit_valid_o,
  input  logic              flit_ready_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  cfg_pkg::wb_addr_t wb_adr_i,
  input  cfg_pkg::wb_data_t wb_dat_i,
  output cfg_pkg::wb_data_t wb_dat_o,
  output logic              wb_ack_o,
  output logic              ddr_rcv_clk_o,
  output link_pkg::lanes_t  ddr_o,
  input  logic              ddr_rcv_clk_i,
  input  link_pkg::lanes_t  ddr_i
);

  link_pkg::flit_t tx_flit;
  logic            tx_flit_valid;
  logic            tx_flit_ready;
  link_pkg::beat_t tx_beat;
  logic            tx_beat_valid;
  logic            tx_beat_ready;
  link_pkg::beat_t rx_beat;
  logic            rx_beat_valid;
  logic            rx_beat_ready;
  link_pkg::beat_t rx_fifo_beat;
  logic            rx_fifo_valid;
  logic            rx_fifo_ready;

  link_cfg_if link_cfg ();

  //////////////////////////////////////////////////////////////////////
  // Transmit pipeline
  //////////////////////////////////////////////////////////////////////

  stream_fifo #(
    .data_t ( link_pkg::flit_t      ),
    .Depth  ( link_pkg::TxFifoDepth )
  ) i_tx_fifo (
    .clk_i    ( clk_i          ),
    .arst_n_i ( arst_n_i       ),
    .clear_i  ( link_cfg.clear ),
    .data_i   ( flit_i         ),
    .valid_i  ( flit_valid_i   ),
    .ready_o  ( flit_ready_o   ),
    .data_o   ( tx_flit        ),
    .valid_o  ( tx_flit_valid  ),
    .ready_i  ( tx_flit_ready  )
  );

  flit_serializer i_flit_serializer (
    .clk_i        ( clk_i         ),
    .arst_n_i     ( arst_n_i      ),
    .cfg          ( link_cfg      ),
    .flit_i       ( tx_flit       ),
    .flit_valid_i ( tx_flit_valid ),
    .flit_ready_o ( tx_flit_ready ),
    .beat_o       ( tx_beat       ),
    .beat_valid_o ( tx_beat_valid ),
    .beat_ready_i ( tx_beat_ready )
  );

  ddr_tx i_ddr_tx (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .cfg           ( link_cfg      ),
    .beat_i        ( tx_beat       ),
    .beat_valid_i  ( tx_beat_valid ),
    .beat_ready_o  ( tx_beat_ready ),
    .ddr_rcv_clk_o ( ddr_rcv_clk_o ),
    .ddr_o         ( ddr_o         )
  );

  //////////////////////////////////////////////////////////////////////
  // Receive pipeline
  //////////////////////////////////////////////////////////////////////

  ddr_rx i_ddr_rx (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .cfg           ( link_cfg      ),
    .ddr_rcv_clk_i ( ddr_rcv_clk_i ),
    .ddr_i         ( ddr_i         ),
    .beat_o        ( rx_beat       ),
    .beat_valid_o  ( rx_beat_valid ),
    .beat_ready_i  ( rx_beat_ready )
  );

  stream_fifo #(
    .data_t ( link_pkg::beat_t      ),
    .Depth  ( link_pkg::RxFifoDepth )
  ) i_rx_fifo (
    .clk_i    ( clk_i          ),
    .arst_n_i ( arst_n_i       ),
    .clear_i  ( link_cfg.clear ),
    .data_i   ( rx_beat        ),
    .valid_i  ( rx_beat_valid  ),
    .ready_o  ( rx_beat_ready  ),
    .data_o   ( rx_fifo_beat   ),
    .valid_o  ( rx_fifo_valid  ),
    .ready_i  ( rx_fifo_ready  )
  );

  flit_deserializer i_flit_deserializer (
    .clk_i        ( clk_i         ),
    .arst_n_i     ( arst_n_i      ),
    .cfg          ( link_cfg      ),
    .beat_i       ( rx_fifo_beat  ),
    .beat_valid_i ( rx_fifo_valid ),
    .beat_ready_o ( rx_fifo_ready ),
    .flit_o       ( flit_o        ),
    .flit_valid_o ( flit_valid_o  ),
    .flit_ready_i ( flit_ready_i  )
  );

  // Control and status
  link_regs i_link_regs (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .wb_cyc_i ( wb_cyc_i ),
    .wb_stb_i ( wb_stb_i ),
    .wb_we_i  ( wb_we_i  ),
    .wb_adr_i ( wb_adr_i ),
    .wb_dat_i ( wb_dat_i ),
    .wb_dat_o ( wb_dat_o ),
    .wb_ack_o ( wb_ack_o ),
    .cfg      ( link_cfg )
  );

endmodule : serial_link_top

`default_nettype wire

// ==== tests/serial_link_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

// Loopback testbench for the DDR serial link
module serial_link_tb;

  // One test step of the stimulus table
  typedef struct packed {
    cfg_pkg::clk_div_t clk_div;
    logic              link_en;
    logic [7:0]        num_flits;
    logic              flit_ready;
    cfg_pkg::wb_data_t status;
  } row_t;

  localparam int                NumRows      = 6;
  localparam int                HalfPeriod   = 4;
  localparam int                DriveDelay   = 1;
  localparam int                IdleWindow   = 32;
  localparam int                RxSettle     = 8;
  localparam cfg_pkg::wb_addr_t UnmappedAddr = 8'h20;

  logic              clk_i;
  logic              arst_n_i;
  link_pkg::flit_t   flit_i;
  logic              flit_valid_i;
  logic              flit_ready_o;
  link_pkg::flit_t   flit_o;
  logic              flit_valid_o;
  logic              flit_ready_i;
  logic              wb_cyc_i;
  logic              wb_stb_i;
  logic              wb_we_i;
  cfg_pkg::wb_addr_t wb_adr_i;
  cfg_pkg::wb_data_t wb_dat_i;
  cfg_pkg::wb_data_t wb_dat_o;
  logic              wb_ack_o;
  logic              ddr_clk;
  link_pkg::lanes_t  ddr_lanes;

  row_t              rows [NumRows];
  link_pkg::flit_t   sent_q [$];
  integer            seed;
  int unsigned       flits_seen;
  int unsigned       tx_total;
  int unsigned       rx_total;
  logic              watch_idle;
  logic              table_loaded;

  // Lanes and forwarded clock looped straight back
  serial_link_top i_dut (
    .clk_i         ( clk_i        ),
    .arst_n_i      ( arst_n_i     ),
    .flit_i        ( flit_i       ),
    .flit_valid_i  ( flit_valid_i ),
    .flit_ready_o  ( flit_ready_o ),
    .flit_o        ( flit_o       ),
    .flit_valid_o  ( flit_valid_o ),
    .flit_ready_i  ( flit_ready_i ),
    .wb_cyc_i      ( wb_cyc_i     ),
    .wb_stb_i      ( wb_stb_i     ),
    .wb_we_i       ( wb_we_i      ),
    .wb_adr_i      ( wb_adr_i     ),
    .wb_dat_i      ( wb_dat_i     ),
    .wb_dat_o      ( wb_dat_o     ),
    .wb_ack_o      ( wb_ack_o     ),
    .ddr_rcv_clk_o ( ddr_clk      ),
    .ddr_o         ( ddr_lanes    ),
    .ddr_rcv_clk_i ( ddr_clk      ),
    .ddr_i         ( ddr_lanes    )
  );

  initial begin
    clk_i = 1'b0;
    forever #HalfPeriod clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_flit(input string name, input link_pkg::flit_t got,
                            input link_pkg::flit_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input cfg_pkg::wb_data_t got,
                            input cfg_pkg::wb_data_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus and stream drivers
  //////////////////////////////////////////////////////////////////////

  // Ack must follow the request by exactly one cycle
  task automatic wb_access(input logic we, input cfg_pkg::wb_addr_t addr,
                           input cfg_pkg::wb_data_t wdata,
                           output cfg_pkg::wb_data_t rdata);
    @(posedge clk_i);
    #DriveDelay;
    if (wb_ack_o) begin
      stop_with_failure("Wishbone ack stayed high for more than one cycle");
    end
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = addr;
    wb_dat_i = wdata;
    @(negedge clk_i);
    if (wb_ack_o) begin
      stop_with_failure($sformatf("Wishbone ack before request to 0x%h was sampled", addr));
    end
    @(posedge clk_i);
    #DriveDelay;
    if (!wb_ack_o) begin
      stop_with_failure($sformatf("no Wishbone ack one cycle after request to 0x%h", addr));
    end
    rdata    = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input cfg_pkg::wb_addr_t addr, input cfg_pkg::wb_data_t data);
    cfg_pkg::wb_data_t ignored;
    wb_access(1'b1, addr, data, ignored);
  endtask

  task automatic wb_read(input cfg_pkg::wb_addr_t addr, output cfg_pkg::wb_data_t data);
    wb_access(1'b0, addr, '0, data);
  endtask

  task automatic check_reg(input cfg_pkg::wb_addr_t addr, input cfg_pkg::wb_data_t exp,
                           input string name);
    cfg_pkg::wb_data_t data;
    wb_read(addr, data);
    check_word(name, data, exp);
  endtask

  task automatic send_flit(input link_pkg::flit_t flit);
    @(posedge clk_i);
    #DriveDelay;
    flit_i       = flit;
    flit_valid_i = 1'b1;
    while (!flit_ready_o) begin
      @(posedge clk_i);
      #DriveDelay;
    end
    sent_q.push_back(flit);
    @(posedge clk_i);
    #DriveDelay;
    flit_valid_i = 1'b0;
  endtask

  // Receive side keeps the beat FIFO plus one flit in the deserializer
  function automatic int unsigned deliverable(input row_t row);
    int unsigned held;
    held = link_pkg::RxFifoDepth / link_pkg::BeatsPerFlit + 1;
    if (row.flit_ready || row.num_flits < held) begin
      return row.num_flits;
    end
    return held;
  endfunction

  // Flit scoreboard sampled at the falling clock edge
  always @(negedge clk_i) begin
    if (watch_idle && (ddr_clk || flit_valid_o)) begin
      stop_with_failure("forwarded clock or flit_valid_o became active with the link disabled");
    end
    if (flit_valid_o && flit_ready_i) begin
      if (sent_q.size() == 0) begin
        stop_with_failure("flit_o delivered a flit that was never sent");
      end else begin
        check_flit("flit_o", flit_o, sent_q.pop_front());
        flits_seen++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test steps
  //////////////////////////////////////////////////////////////////////

  task automatic load_table();
    //          clk_div link_en flits  ready  STATUS
    rows[0] = '{8'd2,   1'b1,   8'd4,  1'b1,  32'h0};
    rows[1] = '{8'd4,   1'b1,   8'd5,  1'b1,  32'h0};
    rows[2] = '{8'd7,   1'b1,   8'd3,  1'b1,  32'h0};
    rows[3] = '{8'd3,   1'b0,   8'd3,  1'b1,  32'h0};
    rows[4] = '{8'd4,   1'b1,   8'd6,  1'b0,  32'h1};
    rows[5] = '{8'd1,   1'b1,   8'd4,  1'b1,  32'h0};
  endtask

  task automatic check_reset_state();
    check_reg(cfg_pkg::AddrCtrl, 32'h0, "CTRL");
    check_reg(cfg_pkg::AddrClkDiv, cfg_pkg::wb_data_t'(cfg_pkg::ClkDivReset), "CLK_DIV");
    check_reg(cfg_pkg::AddrStatus, 32'h0, "STATUS");
    check_reg(cfg_pkg::AddrTxCount, 32'h0, "TX_COUNT");
    check_reg(cfg_pkg::AddrRxCount, 32'h0, "RX_COUNT");
    check_reg(UnmappedAddr, 32'h0, "unmapped");
    wb_write(UnmappedAddr, '1);
    check_reg(UnmappedAddr, 32'h0, "unmapped");
    check_reg(cfg_pkg::AddrCtrl, 32'h0, "CTRL");
    check_reg(cfg_pkg::AddrClkDiv, cfg_pkg::wb_data_t'(cfg_pkg::ClkDivReset), "CLK_DIV");
  endtask

  task automatic recover_from_overflow();
    wb_write(cfg_pkg::AddrStatus, 32'h1 << cfg_pkg::StatusOverflowBit);
    wb_write(cfg_pkg::AddrCtrl, (32'h1 << cfg_pkg::CtrlClearBit) |
                                (32'h1 << cfg_pkg::CtrlLinkEnBit));
    check_reg(cfg_pkg::AddrStatus, 32'h0, "STATUS");
    check_reg(cfg_pkg::AddrTxCount, 32'h0, "TX_COUNT");
    check_reg(cfg_pkg::AddrRxCount, 32'h0, "RX_COUNT");
    // Flits dropped on the wire will never arrive
    sent_q.delete();
    tx_total = 0;
    rx_total = 0;
  endtask

  task automatic run_row(input row_t row);
    cfg_pkg::clk_div_t exp_div;
    cfg_pkg::wb_data_t data;
    int unsigned       target;
    int unsigned       idx;
    exp_div = (row.clk_div < cfg_pkg::MinClkDiv) ? cfg_pkg::MinClkDiv : row.clk_div;
    wb_write(cfg_pkg::AddrClkDiv, cfg_pkg::wb_data_t'(row.clk_div));
    check_reg(cfg_pkg::AddrClkDiv, cfg_pkg::wb_data_t'(exp_div), "CLK_DIV");
    wb_write(cfg_pkg::AddrCtrl, cfg_pkg::wb_data_t'(row.link_en));
    flit_ready_i = row.flit_ready;
    target       = flits_seen + deliverable(row);
    watch_idle   = ~row.link_en;
    for (idx = 0; idx < row.num_flits; idx++) begin
      send_flit({$random(seed), $random(seed)});
    end
    if (!row.link_en) begin
      repeat (IdleWindow) @(posedge clk_i);
      #DriveDelay;
      if (flit_ready_o) begin
        stop_with_failure("flit_ready_o still high with the link disabled and the path full");
      end
      watch_idle = 1'b0;
      wb_write(cfg_pkg::AddrCtrl, 32'h1 << cfg_pkg::CtrlLinkEnBit);
    end
    if (!row.flit_ready) begin
      do begin
        wb_read(cfg_pkg::AddrTxCount, data);
      end while (data != cfg_pkg::wb_data_t'(tx_total + row.num_flits));
      // Last beat still crosses the receive synchroniser
      repeat (RxSettle) @(posedge clk_i);
      #DriveDelay;
      flit_ready_i = 1'b1;
    end
    while (flits_seen < target) begin
      @(posedge clk_i);
    end
    tx_total += row.num_flits;
    rx_total += deliverable(row);
    check_reg(cfg_pkg::AddrTxCount, cfg_pkg::wb_data_t'(tx_total), "TX_COUNT");
    check_reg(cfg_pkg::AddrRxCount, cfg_pkg::wb_data_t'(rx_total), "RX_COUNT");
    check_reg(cfg_pkg::AddrStatus, row.status, "STATUS");
    if (row.status[cfg_pkg::StatusOverflowBit]) begin
      recover_from_overflow();
    end
  endtask

  // Watchdog scaled to the flits in the table
  initial begin
    int unsigned max_div;
    int unsigned total_flits;
    int unsigned limit;
    wait (table_loaded);
    max_div     = 0;
    total_flits = 0;
    for (int r = 0; r < NumRows; r++) begin
      total_flits += rows[r].num_flits;
      if (rows[r].clk_div > max_div) begin
        max_div = rows[r].clk_div;
      end
    end
    limit = total_flits * (2 * link_pkg::BeatsPerFlit * max_div + 12) + 2000;
    repeat (limit) @(posedge clk_i);
    stop_with_failure($sformatf("timeout after %0d cycles without finishing the tests", limit));
  end

  initial begin
    seed         = 32'h4faea8a9;
    flits_seen   = 0;
    tx_total     = 0;
    rx_total     = 0;
    watch_idle   = 1'b0;
    table_loaded = 1'b0;
    arst_n_i     = 1'b0;
    flit_i       = '0;
    flit_valid_i = 1'b0;
    flit_ready_i = 1'b0;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    wb_we_i      = 1'b0;
    wb_adr_i     = '0;
    wb_dat_i     = '0;
    load_table();
    table_loaded = 1'b1;
    repeat (4) @(posedge clk_i);
    #DriveDelay;
    arst_n_i = 1'b1;
    check_reset_state();
    for (int r = 0; r < NumRows; r++) begin
      run_row(rows[r]);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule : serial_link_tb

`default_nettype wire

// ==== src.f ====
design/link_pkg.sv
design/cfg_pkg.sv
design/link_cfg_if.sv
design/stream_fifo.sv
design/flit_serializer.sv
design/ddr_tx.sv
design/ddr_rx.sv
design/flit_deserializer.sv
design/link_regs.sv
design/serial_link_top.sv
tests/serial_link_tb.sv

// ==== Bender.yml ====
package:
  name: serial_link

sources:
  - design/link_pkg.sv
  - design/cfg_pkg.sv
  - design/link_cfg_if.sv
  - design/stream_fifo.sv
  - design/flit_serializer.sv
  - design/ddr_tx.sv
  - design/ddr_rx.sv
  - design/flit_deserializer.sv
  - design/link_regs.sv
  - design/serial_link_top.sv
  - target: test
    files:
      - tests/serial_link_tb.sv
